// File: verilog/ppu_pkg.sv
// Shared PPU types and constants; nametables are horizontal only and the register layout is the classic one
package ppu_pkg;

	// Frame sequencer states
	typedef enum logic [3:0] {
		SEQ_IDLE,
		SEQ_PAL_WAIT_START,
		SEQ_PAL_WAIT_DONE,
		SEQ_SPR_WAIT_START,
		SEQ_SPR_WAIT_DONE,
		SEQ_GRP_START,
		SEQ_GRP_WAIT_START,
		SEQ_GRP_WAIT_DONE,
		SEQ_LINE_GAP,
		SEQ_DISPLAY_WAIT
	} seq_state_t;

	// Renderer fetch states, one video memory read per state
	typedef enum logic [3:0] {
		FETCH_IDLE,
		FETCH_NT,
		FETCH_ATTR,
		FETCH_BG_LO,
		FETCH_BG_HI,
		FETCH_S0_LO,
		FETCH_S0_HI,
		FETCH_S1_LO,
		FETCH_S1_HI,
		FETCH_PIX
	} fetch_state_t;

	// Video memory map
	localparam logic [15:0] NAMETABLE_BASE  = 16'h2000;
	localparam logic [15:0] ATTR_OFFSET     = 16'h03C0;
	localparam logic [15:0] PALETTE_BASE    = 16'h3F00;
	localparam logic [15:0] PATTERN_HI_BASE = 16'h1000;

	// Status register offset in the processor register window
	localparam logic [2:0] STATUS_ADDR = 3'd2;

	// ppu_ctrl bits
	localparam int CTRL_NT_X   = 0;
	localparam int CTRL_SPR_PT = 3;
	localparam int CTRL_BG_PT  = 4;

	// ppu_mask bits
	localparam int MASK_BG_EN  = 3;
	localparam int MASK_SPR_EN = 4;

	// ppu_status bits
	localparam int STAT_OVERFLOW = 5;
	localparam int STAT_HIT      = 6;
	localparam int STAT_VBLANK   = 7;

endpackage

// File: verilog/ppu_palette_load.sv
// Needs vram_data one cycle after vram_addr; palette holds garbage until the first load has run
`timescale 1ns/1ps

module ppu_palette_load (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	output logic             busy,
	output logic [15:0]      vram_addr,
	input  logic [7:0]       vram_data,
	output logic [31:0][7:0] palette
);

	// Address counter, runs two past the last entry to drain the read latency
	logic [5:0] cnt;
	// Byte on vram_data this cycle is wanted
	logic       st_vld;
	// Palette slot of that byte
	logic [4:0] st_idx;

	// Only meaningful while busy, the core mux picks the renderer otherwise
	assign vram_addr = ppu_pkg::PALETTE_BASE + {11'd0, cnt[4:0]};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy   <= 1'b0;
			cnt    <= 6'd0;
			st_vld <= 1'b0;
		end else begin
			// Addresses 0..31 produce data one cycle later
			st_vld <= busy && !cnt[5];
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					cnt  <= 6'd0;
				end
			end else begin
				cnt <= cnt + 6'd1;
				// Last byte was stored on the previous edge
				if (cnt == 6'd33)
					busy <= 1'b0;
			end
		end
	end

	// Palette array and index pipe
	always_ff @(posedge clk) begin
		st_idx <= cnt[4:0];
		if (st_vld)
			palette[st_idx] <= vram_data;
	end

	// Sequencer only asks for a load once the previous one has finished
	assert property (@(posedge clk) disable iff (!rst) $rose(start) |-> !busy);

endmodule

// File: verilog/ppu_sprite_eval.sv
// Sprites are 8x8 and unflipped; at most 64 sprites, two kept per row, scan stops at the third hit
`timescale 1ns/1ps

module ppu_sprite_eval #(
	parameter int SPRITE_COUNT = 64
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	output logic            busy,
	input  logic [8:0]      row,
	output logic [7:0]      spram_addr,
	input  logic [7:0]      spram_data,
	output logic [1:0]      spr_valid,
	output logic [1:0][7:0] spr_tile,
	output logic [1:0][7:0] spr_x,
	output logic [1:0][7:0] spr_attr,
	output logic [1:0][2:0] spr_line,
	output logic [1:0]      spr_is_zero,
	output logic            overflow
);

	// Address phase then data phase for every byte read
	typedef enum logic [1:0] {
		EV_IDLE,
		EV_ADDR,
		EV_DATA
	} ev_state_t;

	ev_state_t  state;
	// Sprite index and byte within its 4-byte entry
	logic [5:0] idx;
	logic [1:0] sub;
	// Slot being filled, slot 1 once slot 0 is taken
	logic       slot;
	// Row offset inside the sprite, wraps large when the sprite starts below the row
	logic [8:0] dy;
	logic       covers;
	logic       last;

	assign spram_addr = {idx, sub};
	assign slot       = spr_valid[0];
	assign dy         = row - {1'b0, spram_data};
	assign covers     = (dy < 9'd8);
	assign last       = (idx == 6'(SPRITE_COUNT - 1));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state       <= EV_IDLE;
			busy        <= 1'b0;
			idx         <= 6'd0;
			sub         <= 2'd0;
			spr_valid   <= 2'b00;
			spr_is_zero <= 2'b00;
			overflow    <= 1'b0;
		end else begin
			overflow <= 1'b0;
			unique case (state)
				EV_IDLE: begin
					if (start) begin
						busy        <= 1'b1;
						idx         <= 6'd0;
						sub         <= 2'd0;
						spr_valid   <= 2'b00;
						spr_is_zero <= 2'b00;
						state       <= EV_ADDR;
					end
				end
				EV_ADDR: state <= EV_DATA;
				EV_DATA: begin
					if (sub == 2'd0 && covers && spr_valid[1]) begin
						// Third sprite on this row
						overflow <= 1'b1;
						busy     <= 1'b0;
						state    <= EV_IDLE;
					end else if ((sub == 2'd0 && !covers) || sub == 2'd3) begin
						if (sub == 2'd3) begin
							spr_valid[slot]   <= 1'b1;
							spr_is_zero[slot] <= (idx == 6'd0);
						end
						sub <= 2'd0;
						if (last) begin
							busy  <= 1'b0;
							state <= EV_IDLE;
						end else begin
							idx   <= idx + 6'd1;
							state <= EV_ADDR;
						end
					end else begin
						// Covering sprite, go on to tile, attribute, X
						sub   <= sub + 2'd1;
						state <= EV_ADDR;
					end
				end
				default: state <= EV_IDLE;
			endcase
		end
	end

	// Slot payload, qualified by spr_valid
	always_ff @(posedge clk) begin
		if (state == EV_DATA) begin
			unique case (sub)
				2'd0: begin
					if (covers && !spr_valid[1])
						spr_line[slot] <= dy[2:0];
				end
				2'd1: spr_tile[slot] <= spram_data;
				2'd2: spr_attr[slot] <= spram_data;
				2'd3: spr_x[slot]    <= spram_data;
			endcase
		end
	end

	// Slots fill in order
	assert property (@(posedge clk) disable iff (!rst) spr_valid[1] |-> spr_valid[0]);

endmodule

// File: verilog/ppu_frame_seq.sv
// SCREEN_W at most 256 and LINE_GAP at least 1; scroll values are sampled, not double buffered
`timescale 1ns/1ps

module ppu_frame_seq #(
	parameter int SCREEN_W = 256,
	parameter int SCREEN_H = 240,
	parameter int LINE_GAP = 300
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       display_done,
	input  logic [7:0] ppu_ctrl,
	input  logic [7:0] scroll_x,
	input  logic [7:0] scroll_y,
	output logic       pal_start,
	input  logic       pal_busy,
	output logic       spr_start,
	input  logic       spr_busy,
	output logic       grp_start,
	input  logic       grp_busy,
	output logic [8:0] row,
	output logic [8:0] col,
	output logic [7:0] scroll_x_lat,
	output logic [7:0] scroll_y_lat,
	output logic       nt_x_lat,
	output logic       bg_pt_lat,
	output logic       spr_pt_lat,
	output logic       frame_end
);

	ppu_pkg::seq_state_t state;
	logic [15:0]         gap_cnt;
	// Column after this group, signed since a row starts left of the screen
	logic signed [9:0]   col_next;
	logic                last_col;
	logic                last_row;

	assign col_next = $signed({col[8], col}) + 10'sd8;
	assign last_col = (col_next >= $signed(10'(SCREEN_W)));
	assign last_row = (row == 9'(SCREEN_H - 1));

	// Horizontal values follow each line, vertical ones once per frame
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			scroll_x_lat <= 8'd0;
			scroll_y_lat <= 8'd0;
			nt_x_lat     <= 1'b0;
			bg_pt_lat    <= 1'b0;
			spr_pt_lat   <= 1'b0;
		end else begin
			if (state == ppu_pkg::SEQ_IDLE || state == ppu_pkg::SEQ_SPR_WAIT_START) begin
				scroll_x_lat <= scroll_x;
				nt_x_lat     <= ppu_ctrl[ppu_pkg::CTRL_NT_X];
			end
			if (state == ppu_pkg::SEQ_PAL_WAIT_START) begin
				scroll_y_lat <= scroll_y;
				bg_pt_lat    <= ppu_ctrl[ppu_pkg::CTRL_BG_PT];
				spr_pt_lat   <= ppu_ctrl[ppu_pkg::CTRL_SPR_PT];
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= ppu_pkg::SEQ_IDLE;
			pal_start <= 1'b0;
			spr_start <= 1'b0;
			grp_start <= 1'b0;
			frame_end <= 1'b0;
			row       <= 9'd0;
			col       <= 9'd0;
			gap_cnt   <= 16'd0;
		end else begin
			frame_end <= 1'b0;
			unique case (state)
				ppu_pkg::SEQ_IDLE: begin
					// Display side is done with the buffer
					if (display_done) begin
						pal_start <= 1'b1;
						row       <= 9'd0;
						state     <= ppu_pkg::SEQ_PAL_WAIT_START;
					end
				end
				ppu_pkg::SEQ_PAL_WAIT_START: begin
					if (pal_busy) begin
						pal_start <= 1'b0;
						state     <= ppu_pkg::SEQ_PAL_WAIT_DONE;
					end
				end
				ppu_pkg::SEQ_PAL_WAIT_DONE: begin
					if (!pal_busy) begin
						spr_start <= 1'b1;
						state     <= ppu_pkg::SEQ_SPR_WAIT_START;
					end
				end
				ppu_pkg::SEQ_SPR_WAIT_START: begin
					if (spr_busy) begin
						spr_start <= 1'b0;
						state     <= ppu_pkg::SEQ_SPR_WAIT_DONE;
					end
				end
				ppu_pkg::SEQ_SPR_WAIT_DONE: begin
					if (!spr_busy) begin
						// Back up by the fine X scroll so groups stay tile aligned
						col   <= 9'd0 - {6'd0, scroll_x_lat[2:0]};
						state <= ppu_pkg::SEQ_GRP_START;
					end
				end
				ppu_pkg::SEQ_GRP_START: begin
					grp_start <= 1'b1;
					state     <= ppu_pkg::SEQ_GRP_WAIT_START;
				end
				ppu_pkg::SEQ_GRP_WAIT_START: begin
					if (grp_busy) begin
						grp_start <= 1'b0;
						state     <= ppu_pkg::SEQ_GRP_WAIT_DONE;
					end
				end
				ppu_pkg::SEQ_GRP_WAIT_DONE: begin
					if (!grp_busy) begin
						if (!last_col) begin
							col   <= col + 9'd8;
							state <= ppu_pkg::SEQ_GRP_START;
						end else if (last_row) begin
							frame_end <= 1'b1;
							state     <= ppu_pkg::SEQ_DISPLAY_WAIT;
						end else begin
							row     <= row + 9'd1;
							gap_cnt <= 16'd0;
							state   <= ppu_pkg::SEQ_LINE_GAP;
						end
					end
				end
				ppu_pkg::SEQ_LINE_GAP: begin
					gap_cnt <= gap_cnt + 16'd1;
					if (gap_cnt == 16'(LINE_GAP - 1)) begin
						spr_start <= 1'b1;
						state     <= ppu_pkg::SEQ_SPR_WAIT_START;
					end
				end
				ppu_pkg::SEQ_DISPLAY_WAIT: begin
					// Wait for the display to pick up the finished frame
					if (!display_done)
						state <= ppu_pkg::SEQ_IDLE;
				end
				default: state <= ppu_pkg::SEQ_IDLE;
			endcase
		end
	end

	// Renderer must not compete with the palette loader for video memory
	assert property (@(posedge clk) disable iff (!rst) grp_start |-> !pal_busy);

endmodule

// File: verilog/ppu_tile_render.sv
// Expects tile-aligned groups from the sequencer; no vertical nametable switch, Y scroll wraps at 256
`timescale 1ns/1ps

module ppu_tile_render #(
	parameter int SCREEN_W = 256
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	output logic             busy,
	input  logic [8:0]       row,
	input  logic [8:0]       col,
	input  logic [7:0]       scroll_x_lat,
	input  logic [7:0]       scroll_y_lat,
	input  logic             nt_x_lat,
	input  logic             bg_pt_lat,
	input  logic             spr_pt_lat,
	input  logic [7:0]       ppu_mask,
	input  logic [31:0][7:0] palette,
	input  logic [1:0]       spr_valid,
	input  logic [1:0][7:0]  spr_tile,
	input  logic [1:0][7:0]  spr_x,
	input  logic [1:0][7:0]  spr_attr,
	input  logic [1:0][2:0]  spr_line,
	output logic [15:0]      vram_addr,
	input  logic [7:0]       vram_data,
	output logic [8:0]       pix_row,
	output logic [8:0]       pix_col,
	output logic [7:0]       pix_data,
	output logic             pix_we,
	output logic [1:0]       hit
);

	ppu_pkg::fetch_state_t state;
	// Pixel step, 0 catches the last byte, 1..8 write
	logic [3:0]       pcnt;
	// Fetched bytes
	logic [7:0]       tile_num;
	logic [7:0]       attr_byte;
	logic [7:0]       bg_lo;
	logic [7:0]       bg_hi;
	logic [1:0][7:0]  spr_lo;
	logic [1:0][7:0]  spr_hi;
	// Scrolled position of this group
	logic [8:0]       wx;
	logic [7:0]       wy;
	logic             nt_sel;
	logic [15:0]      nt_base;
	logic [15:0]      bg_pat;
	logic [1:0][15:0] spr_pat;
	// Pixel datapath
	logic [2:0]       px;
	logic [8:0]       scol;
	logic [1:0]       attr_grp;
	logic [1:0]       bg_px;
	logic [1:0][8:0]  dx;
	logic [1:0][1:0]  spx;
	logic             spr_slot;
	logic             spr_win;
	logic [4:0]       pal_idx;

	// Bit 8 of the X sum crosses into the other nametable
	assign wx      = col + {1'b0, scroll_x_lat};
	assign wy      = row[7:0] + scroll_y_lat;
	assign nt_sel  = nt_x_lat ^ wx[8];
	assign nt_base = ppu_pkg::NAMETABLE_BASE + {5'd0, nt_sel, 10'd0};
	assign bg_pat  = (bg_pt_lat ? ppu_pkg::PATTERN_HI_BASE : 16'h0000) +
		{4'd0, tile_num, 4'd0} + {13'd0, wy[2:0]};

	always_comb begin
		for (int k = 0; k < 2; k++)
			spr_pat[k] = (spr_pt_lat ? ppu_pkg::PATTERN_HI_BASE : 16'h0000) +
				{4'd0, spr_tile[k], 4'd0} + {13'd0, spr_line[k]};
	end

	// Address for the read issued in this state
	always_comb begin
		case (state)
			ppu_pkg::FETCH_NT:    vram_addr = nt_base + {6'd0, wy[7:3], wx[7:3]};
			ppu_pkg::FETCH_ATTR:  vram_addr = nt_base + ppu_pkg::ATTR_OFFSET +
				{10'd0, wy[7:5], wx[7:5]};
			ppu_pkg::FETCH_BG_LO: vram_addr = bg_pat;
			ppu_pkg::FETCH_BG_HI: vram_addr = bg_pat + 16'd8;
			ppu_pkg::FETCH_S0_LO: vram_addr = spr_pat[0];
			ppu_pkg::FETCH_S0_HI: vram_addr = spr_pat[0] + 16'd8;
			ppu_pkg::FETCH_S1_LO: vram_addr = spr_pat[1];
			ppu_pkg::FETCH_S1_HI: vram_addr = spr_pat[1] + 16'd8;
			default:              vram_addr = 16'h0000;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= ppu_pkg::FETCH_IDLE;
			busy  <= 1'b0;
			pcnt  <= 4'd0;
		end else begin
			unique case (state)
				ppu_pkg::FETCH_IDLE: begin
					if (start) begin
						busy  <= 1'b1;
						pcnt  <= 4'd0;
						state <= ppu_pkg::FETCH_NT;
					end
				end
				ppu_pkg::FETCH_NT:    state <= ppu_pkg::FETCH_ATTR;
				ppu_pkg::FETCH_ATTR:  state <= ppu_pkg::FETCH_BG_LO;
				ppu_pkg::FETCH_BG_LO: state <= ppu_pkg::FETCH_BG_HI;
				ppu_pkg::FETCH_BG_HI: state <= ppu_pkg::FETCH_S0_LO;
				ppu_pkg::FETCH_S0_LO: state <= ppu_pkg::FETCH_S0_HI;
				ppu_pkg::FETCH_S0_HI: state <= ppu_pkg::FETCH_S1_LO;
				ppu_pkg::FETCH_S1_LO: state <= ppu_pkg::FETCH_S1_HI;
				ppu_pkg::FETCH_S1_HI: state <= ppu_pkg::FETCH_PIX;
				ppu_pkg::FETCH_PIX: begin
					pcnt <= pcnt + 4'd1;
					if (pcnt == 4'd8) begin
						busy  <= 1'b0;
						state <= ppu_pkg::FETCH_IDLE;
					end
				end
				default: state <= ppu_pkg::FETCH_IDLE;
			endcase
		end
	end

	// Each byte lands one state after its address
	always_ff @(posedge clk) begin
		case (state)
			ppu_pkg::FETCH_ATTR:  tile_num  <= vram_data;
			ppu_pkg::FETCH_BG_LO: attr_byte <= vram_data;
			ppu_pkg::FETCH_BG_HI: bg_lo     <= vram_data;
			ppu_pkg::FETCH_S0_LO: bg_hi     <= vram_data;
			ppu_pkg::FETCH_S0_HI: spr_lo[0] <= vram_data;
			ppu_pkg::FETCH_S1_LO: spr_hi[0] <= vram_data;
			ppu_pkg::FETCH_S1_HI: spr_lo[1] <= vram_data;
			ppu_pkg::FETCH_PIX: begin
				if (pcnt == 4'd0)
					spr_hi[1] <= vram_data;
			end
			default: ;
		endcase
	end

	assign px   = 3'(pcnt - 4'd1);
	assign scol = col + {6'd0, px};

	// Merge one pixel
	always_comb begin
		// 2-bit group from the quadrant of the 32x32 area
		attr_grp = 2'(attr_byte >> {wy[4], wx[4], 1'b0});
		bg_px    = {bg_hi[~px], bg_lo[~px]};
		if (!ppu_mask[ppu_pkg::MASK_BG_EN])
			bg_px = 2'd0;
		for (int k = 0; k < 2; k++) begin
			dx[k]  = scol - {1'b0, spr_x[k]};
			spx[k] = {spr_hi[k][~dx[k][2:0]], spr_lo[k][~dx[k][2:0]]};
			if (!ppu_mask[ppu_pkg::MASK_SPR_EN] || !spr_valid[k] || dx[k] > 9'd7)
				spx[k] = 2'd0;
		end
		// Slot 0 wins between the two sprites when opaque
		spr_slot = (spx[0] == 2'd0);
		// Attribute bit 5 puts the sprite behind opaque background
		spr_win  = (spx[spr_slot] != 2'd0) &&
			(!spr_attr[spr_slot][5] || bg_px == 2'd0);
		if (spr_win)
			pal_idx = {1'b1, spr_attr[spr_slot][1:0], spx[spr_slot]};
		else if (bg_px != 2'd0)
			pal_idx = {1'b0, attr_grp, bg_px};
		else
			pal_idx = 5'd0;
	end

	assign pix_we   = (state == ppu_pkg::FETCH_PIX) && (pcnt != 4'd0) &&
		(scol < 9'(SCREEN_W));
	assign pix_row  = row;
	assign pix_col  = scol;
	assign pix_data = palette[pal_idx];

	// Opaque overlap per slot, only on visible pixels
	assign hit[0] = pix_we && (bg_px != 2'd0) && (spx[0] != 2'd0);
	assign hit[1] = pix_we && (bg_px != 2'd0) && (spx[1] != 2'd0);

endmodule

// File: verilog/ppu_status_reg.sv
// Bits 5 to 7 only; a status read clears all three, but an event in the same cycle still sets its bit
`timescale 1ns/1ps

module ppu_status_reg (
	input  logic       clk,
	input  logic       rst,
	input  logic       frame_end,
	input  logic [1:0] hit,
	input  logic [1:0] spr_is_zero,
	input  logic       overflow,
	input  logic [2:0] cpu_addr,
	input  logic       cpu_read,
	output logic [7:0] ppu_status
);

	logic status_rd;
	// Overlap counts only for the slot holding sprite 0
	logic hit_zero;

	assign status_rd = cpu_read && (cpu_addr == ppu_pkg::STATUS_ADDR);
	assign hit_zero  = |(hit & spr_is_zero);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ppu_status <= 8'h00;
		end else begin
			// Cleared the cycle after the read
			if (status_rd) begin
				ppu_status[ppu_pkg::STAT_OVERFLOW] <= 1'b0;
				ppu_status[ppu_pkg::STAT_HIT]      <= 1'b0;
				ppu_status[ppu_pkg::STAT_VBLANK]   <= 1'b0;
			end
			// Sticky set
			if (frame_end)
				ppu_status[ppu_pkg::STAT_VBLANK] <= 1'b1;
			if (hit_zero)
				ppu_status[ppu_pkg::STAT_HIT] <= 1'b1;
			if (overflow)
				ppu_status[ppu_pkg::STAT_OVERFLOW] <= 1'b1;
		end
	end

	// Low five bits are unused
	assert property (@(posedge clk) disable iff (!rst) ppu_status[4:0] == 5'd0);

endmodule

// File: verilog/ppu_core.sv
// Video and sprite memories are synchronous with one cycle read latency; the pixel sink takes one per cycle
`timescale 1ns/1ps

module ppu_core #(
	parameter int SCREEN_W     = 256,
	parameter int SCREEN_H     = 240,
	parameter int SPRITE_COUNT = 64,
	parameter int LINE_GAP     = 300
) (
	input  logic        clk,
	input  logic        rst,
	output logic [15:0] vram_addr,
	input  logic [7:0]  vram_data,
	output logic [7:0]  spram_addr,
	input  logic [7:0]  spram_data,
	input  logic [2:0]  cpu_addr,
	input  logic        cpu_read,
	input  logic [7:0]  ppu_ctrl,
	input  logic [7:0]  ppu_mask,
	input  logic [7:0]  scroll_x,
	input  logic [7:0]  scroll_y,
	output logic [7:0]  ppu_status,
	input  logic        display_done,
	output logic [8:0]  pix_row,
	output logic [8:0]  pix_col,
	output logic [7:0]  pix_data,
	output logic        pix_we
);

	// Sequencer handshakes
	logic             pal_start, pal_busy;
	logic             spr_start, spr_busy;
	logic             grp_start, grp_busy;
	logic             frame_end;
	// Screen position and latched scroll
	logic [8:0]       row, col;
	logic [7:0]       scroll_x_lat, scroll_y_lat;
	logic             nt_x_lat, bg_pt_lat, spr_pt_lat;
	// Palette and sprite slots
	logic [31:0][7:0] palette;
	logic [1:0]       spr_valid, spr_is_zero;
	logic [1:0][7:0]  spr_tile, spr_x, spr_attr;
	logic [1:0][2:0]  spr_line;
	logic             overflow;
	logic [1:0]       hit;
	// Video memory requests from both readers
	logic [15:0]      pal_vram_addr, rnd_vram_addr;

	ppu_frame_seq #(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H),
		.LINE_GAP(LINE_GAP)
	) u_seq (
		.clk(clk), .rst(rst), .display_done(display_done),
		.ppu_ctrl(ppu_ctrl), .scroll_x(scroll_x), .scroll_y(scroll_y),
		.pal_start(pal_start), .pal_busy(pal_busy),
		.spr_start(spr_start), .spr_busy(spr_busy),
		.grp_start(grp_start), .grp_busy(grp_busy),
		.row(row), .col(col),
		.scroll_x_lat(scroll_x_lat), .scroll_y_lat(scroll_y_lat),
		.nt_x_lat(nt_x_lat), .bg_pt_lat(bg_pt_lat), .spr_pt_lat(spr_pt_lat),
		.frame_end(frame_end)
	);

	ppu_palette_load u_pal (
		.clk(clk), .rst(rst), .start(pal_start), .busy(pal_busy),
		.vram_addr(pal_vram_addr), .vram_data(vram_data), .palette(palette)
	);

	ppu_sprite_eval #(
		.SPRITE_COUNT(SPRITE_COUNT)
	) u_spr (
		.clk(clk), .rst(rst), .start(spr_start), .busy(spr_busy), .row(row),
		.spram_addr(spram_addr), .spram_data(spram_data),
		.spr_valid(spr_valid), .spr_tile(spr_tile), .spr_x(spr_x),
		.spr_attr(spr_attr), .spr_line(spr_line), .spr_is_zero(spr_is_zero),
		.overflow(overflow)
	);

	ppu_tile_render #(
		.SCREEN_W(SCREEN_W)
	) u_rnd (
		.clk(clk), .rst(rst), .start(grp_start), .busy(grp_busy),
		.row(row), .col(col),
		.scroll_x_lat(scroll_x_lat), .scroll_y_lat(scroll_y_lat),
		.nt_x_lat(nt_x_lat), .bg_pt_lat(bg_pt_lat), .spr_pt_lat(spr_pt_lat),
		.ppu_mask(ppu_mask), .palette(palette),
		.spr_valid(spr_valid), .spr_tile(spr_tile), .spr_x(spr_x),
		.spr_attr(spr_attr), .spr_line(spr_line),
		.vram_addr(rnd_vram_addr), .vram_data(vram_data),
		.pix_row(pix_row), .pix_col(pix_col), .pix_data(pix_data), .pix_we(pix_we),
		.hit(hit)
	);

	ppu_status_reg u_stat (
		.clk(clk), .rst(rst), .frame_end(frame_end), .hit(hit),
		.spr_is_zero(spr_is_zero), .overflow(overflow),
		.cpu_addr(cpu_addr), .cpu_read(cpu_read), .ppu_status(ppu_status)
	);

	// Palette loader owns video memory for its whole load
	assign vram_addr = pal_busy ? pal_vram_addr : rnd_vram_addr;

endmodule

// File: dv/ppu_core_tb.sv
// Runs a 16x4 screen with 8 sprites; memory models answer one cycle after the address, the first error stops the run
`timescale 1ns/1ps

module ppu_core_tb;

	localparam int SCREEN_W      = 16;
	localparam int SCREEN_H      = 4;
	localparam int SPRITE_COUNT  = 8;
	localparam int LINE_GAP      = 5;
	localparam int FRAME_TIMEOUT = 20000;

	logic        clk = 1'b0;
	logic        rst;
	logic [15:0] vram_addr;
	logic [7:0]  vram_data = 8'h00;
	logic [7:0]  spram_addr;
	logic [7:0]  spram_data = 8'h00;
	logic [2:0]  cpu_addr;
	logic        cpu_read;
	logic [7:0]  ppu_ctrl;
	logic [7:0]  ppu_mask;
	logic [7:0]  scroll_x;
	logic [7:0]  scroll_y;
	logic [7:0]  ppu_status;
	logic        display_done;
	logic [8:0]  pix_row;
	logic [8:0]  pix_col;
	logic [7:0]  pix_data;
	logic        pix_we;

	// Video and sprite memory contents
	logic [7:0]  vram [0:65535];
	logic [7:0]  spram [0:255];
	logic [31:0] seed = 32'had57_5476;
	// Pixel bookkeeping
	logic [31:0] pix_count;
	logic [31:0] pix_sum;
	logic        last_vld;
	logic [8:0]  last_row;
	logic [8:0]  last_col;
	// Weighted sums of the frames before and after the palette change
	logic [31:0] sum_before;
	logic [31:0] sum_after;

	always #10 clk = ~clk;

	ppu_core #(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H),
		.SPRITE_COUNT(SPRITE_COUNT),
		.LINE_GAP(LINE_GAP)
	) uut (
		.clk(clk), .rst(rst),
		.vram_addr(vram_addr), .vram_data(vram_data),
		.spram_addr(spram_addr), .spram_data(spram_data),
		.cpu_addr(cpu_addr), .cpu_read(cpu_read),
		.ppu_ctrl(ppu_ctrl), .ppu_mask(ppu_mask),
		.scroll_x(scroll_x), .scroll_y(scroll_y),
		.ppu_status(ppu_status), .display_done(display_done),
		.pix_row(pix_row), .pix_col(pix_col), .pix_data(pix_data), .pix_we(pix_we)
	);

	// Synchronous reads, data one cycle after the address
	always @(posedge clk) begin
		vram_data  <= vram[vram_addr];
		spram_data <= spram[spram_addr];
	end

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			pix_count <= 32'd0;
			pix_sum   <= 32'd0;
			last_vld  <= 1'b0;
			last_row  <= 9'd0;
			last_col  <= 9'd0;
		end else if (pix_we) begin
			pix_count <= pix_count + 32'd1;
			// Position weight so a moved pixel changes the sum too
			pix_sum   <= pix_sum + 32'(pix_data) * 32'(pix_col + 9'd1);
			last_vld  <= 1'b1;
			last_row  <= pix_row;
			last_col  <= pix_col;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic report_error(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// Index of the k-th sprite covering row r in index order, -1 if none
	function automatic int covering(input logic [8:0] r, input int k);
		logic [8:0] dy;
		int         n;
		int         found;
		n     = 0;
		found = -1;
		for (int i = 0; i < SPRITE_COUNT; i++) begin
			dy = r - {1'b0, spram[8'(4 * i)]};
			if (dy < 9'd8 && found < 0) begin
				if (n == k)
					found = i;
				n++;
			end
		end
		return found;
	endfunction

	// Attribute group and 2-bit background pixel at screen position
	function automatic logic [3:0] bg_lookup(input logic [8:0] r, input logic [8:0] c);
		logic [8:0]  wx;
		logic [7:0]  wy;
		logic [15:0] base;
		logic [7:0]  tile;
		logic [7:0]  attr;
		logic [15:0] pa;
		logic [2:0]  b;
		logic [1:0]  grp;
		logic [1:0]  px;
		wx   = c + {1'b0, scroll_x};
		wy   = r[7:0] + scroll_y;
		// Past X 255 the other horizontal nametable takes over
		base = ppu_pkg::NAMETABLE_BASE +
			((ppu_ctrl[ppu_pkg::CTRL_NT_X] ^ wx[8]) ? 16'h0400 : 16'h0000);
		tile = vram[base + {6'd0, wy[7:3], wx[7:3]}];
		attr = vram[base + ppu_pkg::ATTR_OFFSET + {10'd0, wy[7:5], wx[7:5]}];
		grp  = 2'(attr >> {wy[4], wx[4], 1'b0});
		pa   = (ppu_ctrl[ppu_pkg::CTRL_BG_PT] ? ppu_pkg::PATTERN_HI_BASE : 16'h0000) +
			{4'd0, tile, 4'd0} + {13'd0, wy[2:0]};
		// Leftmost pixel is bit 7
		b    = 3'd7 - wx[2:0];
		px   = {vram[pa + 16'd8][b], vram[pa][b]};
		if (!ppu_mask[ppu_pkg::MASK_BG_EN])
			px = 2'd0;
		return {grp, px};
	endfunction

	// Pixel of sprite s at screen position, zero when off or disabled
	function automatic logic [1:0] spr_lookup(input logic [8:0] r, input logic [8:0] c,
		input int s);
		logic [8:0]  dy;
		logic [8:0]  dx;
		logic [15:0] pa;
		logic [2:0]  b;
		if (s < 0 || !ppu_mask[ppu_pkg::MASK_SPR_EN])
			return 2'd0;
		dy = r - {1'b0, spram[8'(4 * s)]};
		dx = c - {1'b0, spram[8'(4 * s + 3)]};
		if (dx > 9'd7)
			return 2'd0;
		pa = (ppu_ctrl[ppu_pkg::CTRL_SPR_PT] ? ppu_pkg::PATTERN_HI_BASE : 16'h0000) +
			{4'd0, spram[8'(4 * s + 1)], 4'd0} + {13'd0, dy[2:0]};
		b  = 3'd7 - dx[2:0];
		return {vram[pa + 16'd8][b], vram[pa][b]};
	endfunction

	// Expected palette byte after merging background and the two kept sprites
	function automatic logic [7:0] ref_pixel(input logic [8:0] r, input logic [8:0] c);
		logic [3:0] bg;
		logic [1:0] sp;
		logic [1:0] cand;
		logic [7:0] attr;
		logic [4:0] idx;
		int         s;
		bg   = bg_lookup(r, c);
		sp   = 2'd0;
		attr = 8'd0;
		// Slot 1 first, an opaque slot 0 overrides it
		for (int k = 1; k >= 0; k--) begin
			s    = covering(r, k);
			cand = spr_lookup(r, c, s);
			if (cand != 2'd0) begin
				sp   = cand;
				attr = spram[8'(4 * s + 2)];
			end
		end
		// Attribute bit 5 hides the sprite behind opaque background
		if (sp != 2'd0 && (!attr[5] || bg[1:0] == 2'd0))
			idx = {1'b1, attr[1:0], sp};
		else if (bg[1:0] != 2'd0)
			idx = {1'b0, bg[3:2], bg[1:0]};
		else
			idx = 5'd0;
		return vram[ppu_pkg::PALETTE_BASE + {11'd0, idx}];
	endfunction

	// Sprite-zero hit and overflow expected for the whole frame
	function automatic logic [1:0] frame_flags();
		logic       hit;
		logic       ovf;
		logic [3:0] bg;
		hit = 1'b0;
		ovf = 1'b0;
		for (int r = 0; r < SCREEN_H; r++) begin
			if (covering(9'(r), 2) >= 0)
				ovf = 1'b1;
			// Sprite 0 always lands in slot 0 when it covers the row
			if (covering(9'(r), 0) == 0) begin
				for (int c = 0; c < SCREEN_W; c++) begin
					bg = bg_lookup(9'(r), 9'(c));
					if (bg[1:0] != 2'd0 && spr_lookup(9'(r), 9'(c), 0) != 2'd0)
						hit = 1'b1;
				end
			end
		end
		return {hit, ovf};
	endfunction

	assert property (@(posedge clk) disable iff (!rst)
		pix_we |-> pix_data == ref_pixel(pix_row, pix_col))
	else
		report_error($sformatf("[FAIL] %0t pix_data at row %0d col %0d expected %02h got %02h",
			$time, $sampled(pix_row), $sampled(pix_col),
			ref_pixel($sampled(pix_row), $sampled(pix_col)), $sampled(pix_data)));

	// Left to right inside a row
	assert property (@(posedge clk) disable iff (!rst)
		pix_we && last_vld && pix_row == last_row |-> pix_col > last_col)
	else
		report_error($sformatf("[FAIL] %0t pix_col expected above %0d got %0d",
			$time, $sampled(last_col), $sampled(pix_col)));

	assert property (@(posedge clk) disable iff (!rst) pix_we |-> pix_col < 9'(SCREEN_W))
	else
		report_error($sformatf("[FAIL] %0t pix_col expected below %0d got %0d",
			$time, SCREEN_W, $sampled(pix_col)));

	task automatic fill_memories();
		for (int a = 0; a < 65536; a++) begin
			seed         = xorshift(seed);
			vram[16'(a)] = seed[7:0] ^ 8'(a) ^ 8'(a >> 8);
		end
		for (int a = 0; a < 256; a++) begin
			seed          = xorshift(seed);
			spram[8'(a)]  = seed[15:8] ^ 8'(a);
		end
		// Tile 5A in the upper table, left half color 1, right half color 3
		for (int y = 0; y < 8; y++) begin
			vram[16'h15A0 + 16'(y)] = 8'hFF;
			vram[16'h15A8 + 16'(y)] = 8'h0F;
		end
	endtask

	task automatic new_palette();
		for (int i = 0; i < 32; i++) begin
			seed = xorshift(seed);
			vram[ppu_pkg::PALETTE_BASE + 16'(i)] = seed[23:16];
		end
	endtask

	task automatic place_sprite(input int i, input logic [7:0] y, input logic [7:0] tile,
		input logic [7:0] attr, input logic [7:0] x);
		spram[8'(4 * i)]     = y;
		spram[8'(4 * i + 1)] = tile;
		spram[8'(4 * i + 2)] = attr;
		spram[8'(4 * i + 3)] = x;
	endtask

	// Park every sprite below the small screen
	task automatic clear_sprites();
		for (int i = 0; i < SPRITE_COUNT; i++)
			spram[8'(4 * i)] = 8'hF0;
	endtask

	task automatic read_status();
		@(posedge clk);
		#2;
		cpu_addr = ppu_pkg::STATUS_ADDR;
		cpu_read = 1'b1;
		@(posedge clk);
		#2;
		cpu_read = 1'b0;
		cpu_addr = 3'd0;
		assert (ppu_status == 8'h00)
		else
			report_error($sformatf("[FAIL] %0t ppu_status after read expected 00 got %02h",
				$time, ppu_status));
	endtask

	task automatic run_frame(output logic [31:0] frame_sum);
		logic [1:0]  flags;
		logic [7:0]  exp_status;
		logic [31:0] count0;
		logic [31:0] sum0;
		int          n;
		flags  = frame_flags();
		count0 = pix_count;
		sum0   = pix_sum;
		@(posedge clk);
		#2;
		display_done = 1'b1;
		n = 0;
		while (!frame_end_seen() && n < FRAME_TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!frame_end_seen())
			report_error("Timed out waiting for the end of the frame");
		#1;
		display_done = 1'b0;
		// Vertical blank lands one cycle after frame_end
		@(posedge clk);
		#2;
		assert (pix_count - count0 == 32'(SCREEN_W * SCREEN_H))
		else
			report_error($sformatf("[FAIL] %0t pixel count expected %0d got %0d",
				$time, SCREEN_W * SCREEN_H, pix_count - count0));
		exp_status = {1'b1, flags[1], flags[0], 5'd0};
		assert (ppu_status == exp_status)
		else
			report_error($sformatf("[FAIL] %0t ppu_status expected %02h got %02h",
				$time, exp_status, ppu_status));
		frame_sum = pix_sum - sum0;
		read_status();
	endtask

	function automatic logic frame_end_seen();
		return uut.frame_end;
	endfunction

	initial begin
		rst          = 1'b0;
		cpu_addr     = 3'd0;
		cpu_read     = 1'b0;
		display_done = 1'b0;
		// Nametable 1 first, sprites from the upper pattern table
		ppu_ctrl     = 8'h09;
		ppu_mask     = 8'h08;
		scroll_x     = 8'hF5;
		scroll_y     = 8'h13;
		fill_memories();
		clear_sprites();
		// Sprite 0 in front, sprite 1 behind the background
		place_sprite(0, 8'h00, 8'h5A, 8'h01, 8'h02);
		place_sprite(1, 8'h01, 8'h5A, 8'h22, 8'h06);
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b1;
		// Background only, the X scroll crosses the nametable seam
		run_frame(sum_before);
		ppu_mask = 8'h18;
		run_frame(sum_before);
		// Sprites 1, 2 and 3 all cover rows 2 and 3
		scroll_x = 8'h03;
		scroll_y = 8'hFE;
		clear_sprites();
		place_sprite(1, 8'h00, 8'h5A, 8'h00, 8'h00);
		place_sprite(2, 8'h02, 8'h5A, 8'h23, 8'h04);
		place_sprite(3, 8'h01, 8'h5A, 8'h02, 8'h08);
		run_frame(sum_before);
		// Same scene again with other palette bytes
		new_palette();
		run_frame(sum_after);
		assert (sum_after != sum_before)
		else
			report_error("New palette bytes did not change the pixels of the next frame");
		$display("Regression passed");
		$finish;
	end

endmodule

// File: sim.f
verilog/ppu_pkg.sv
verilog/ppu_palette_load.sv
verilog/ppu_sprite_eval.sv
verilog/ppu_frame_seq.sv
verilog/ppu_tile_render.sv
verilog/ppu_status_reg.sv
verilog/ppu_core.sv
dv/ppu_core_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module ppu_core_tb -f sim.f -o ppu_core_sim &&
./obj_dir/ppu_core_sim ||
{ echo "build or simulation did not complete cleanly"; exit 1; }
